/* design/simt_pkg.sv */
`default_nettype none

package simt_pkg;

    // Core sizes
    localparam int NUM_WARPS = 4;
    localparam int NUM_LANES = 4;
    localparam int NUM_REGS  = 8;

    // Instruction field positions
    localparam int OPC_MSB    = 31;
    localparam int OPC_LSB    = 28;
    localparam int SCALAR_BIT = 27;
    localparam int RD_LSB     = 24;
    localparam int RS1_LSB    = 21;
    localparam int RS2_LSB    = 18;
    localparam int IMM_W      = 18;

    typedef logic [31:0] data_t;
    typedef logic [31:0] instr_t;
    typedef logic [15:0] pc_t;
    typedef logic [2:0]  reg_addr_t;
    typedef logic [1:0]  warp_idx_t;
    typedef logic [2:0]  warp_count_t;
    typedef logic [NUM_LANES-1:0] lane_mask_t;
    typedef logic [$clog2(NUM_LANES)-1:0] lane_idx_t;

    // Codes above OP_HALT decode as halt
    typedef enum logic [3:0] {
        OP_ADD    = 4'd0,
        OP_SUB    = 4'd1,
        OP_AND    = 4'd2,
        OP_OR     = 4'd3,
        OP_XOR    = 4'd4,
        OP_SLT    = 4'd5,
        OP_ADDI   = 4'd6,
        OP_LI     = 4'd7,
        OP_LANEID = 4'd8,
        OP_BNE    = 4'd9,
        OP_HALT   = 4'd10
    } opcode_e;

    // Life cycle of one warp slot
    typedef enum logic [2:0] {
        WARP_IDLE    = 3'd0,
        WARP_FETCH   = 3'd1,
        WARP_READY   = 3'd2,
        WARP_DECODE  = 3'd3,
        WARP_EXECUTE = 3'd4,
        WARP_UPDATE  = 3'd5,
        WARP_DONE    = 3'd6
    } warp_state_e;

endpackage

`default_nettype wire

/* design/warp_scheduler.sv */
`timescale 1ns/10ps
`default_nettype none

module warp_scheduler (
    input  wire                       clk,
    input  wire                       reset,
    input  logic                      start,
    input  simt_pkg::warp_count_t     num_warps,
    input  simt_pkg::pc_t             base_pc,
    output logic [simt_pkg::NUM_WARPS-1:0] imem_valid,
    output simt_pkg::pc_t             imem_addr [simt_pkg::NUM_WARPS],
    input  logic [simt_pkg::NUM_WARPS-1:0] imem_ready,
    input  simt_pkg::instr_t          imem_data [simt_pkg::NUM_WARPS],
    output simt_pkg::warp_idx_t       cur_warp,
    output simt_pkg::instr_t          cur_instr,
    output logic                      decoding,
    output logic                      executing,
    input  logic                      is_branch,
    input  logic                      is_halt,
    input  simt_pkg::data_t           branch_imm,
    input  logic                      branch_ne,
    output logic                      done
);
    import simt_pkg::*;

    warp_state_e state [NUM_WARPS];
    pc_t         pc [NUM_WARPS];
    instr_t      instr [NUM_WARPS];
    pc_t         next_pc;
    pc_t         cur_pc;
    logic        running;
    logic        any_busy;
    logic        path_free;
    logic        pick_valid;
    warp_idx_t   pick_warp;

    assign cur_pc    = pc[cur_warp];
    assign cur_instr = instr[cur_warp];
    assign decoding  = (state[cur_warp] == WARP_DECODE);
    assign executing = (state[cur_warp] == WARP_EXECUTE);

    // Path is held only through decode and execute
    assign path_free = !(decoding || executing);

    for (genvar w = 0; w < NUM_WARPS; w++) begin : g_fetch
        assign imem_valid[w] = (state[w] == WARP_FETCH);
        assign imem_addr[w]  = pc[w];
    end

    // Round-robin search begins after the last picked warp
    always_comb begin
        warp_idx_t cand;
        pick_valid = 1'b0;
        pick_warp  = cur_warp;
        for (int i = 1; i <= NUM_WARPS; i++) begin
            cand = warp_idx_t'(cur_warp + i);
            if (!pick_valid && state[cand] == WARP_READY) begin
                pick_valid = 1'b1;
                pick_warp  = cand;
            end
        end
    end

    always_comb begin
        any_busy = 1'b0;
        for (int w = 0; w < NUM_WARPS; w++) begin
            if (state[w] != WARP_IDLE && state[w] != WARP_DONE)
                any_busy = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            running  <= 1'b0;
            done     <= 1'b0;
            cur_warp <= warp_idx_t'(NUM_WARPS - 1);
            for (int w = 0; w < NUM_WARPS; w++) begin
                state[w] <= WARP_IDLE;
                pc[w]    <= '0;
            end
        end else begin
            done <= running && !any_busy;
            if (start && !running) begin
                running <= 1'b1;
                for (int w = 0; w < NUM_WARPS; w++) begin
                    if (w < num_warps) begin
                        state[w] <= WARP_FETCH;
                        pc[w]    <= base_pc;
                    end
                end
            end
            for (int w = 0; w < NUM_WARPS; w++) begin
                case (state[w])
                    WARP_FETCH:   if (imem_ready[w]) state[w] <= WARP_READY;
                    WARP_DECODE:  state[w] <= WARP_EXECUTE;
                    WARP_EXECUTE: state[w] <= WARP_UPDATE;
                    WARP_UPDATE: begin
                        if (is_halt) begin
                            state[w] <= WARP_DONE;
                        end else begin
                            pc[w]    <= next_pc;
                            state[w] <= WARP_FETCH;
                        end
                    end
                    default: ;
                endcase
            end
            if (path_free && pick_valid) begin
                cur_warp         <= pick_warp;
                state[pick_warp] <= WARP_DECODE;
            end
        end
    end

    // Fetched words and branch target
    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WARPS; w++) begin
            if (imem_valid[w] && imem_ready[w])
                instr[w] <= imem_data[w];
        end
        if (executing)
            next_pc <= (is_branch && branch_ne) ? cur_pc + pc_t'(branch_imm) : cur_pc + pc_t'(1);
    end

    assert property (@(posedge clk) disable iff (reset) executing |=> !executing);

    for (genvar w = 0; w < NUM_WARPS; w++) begin : g_fetch_chk
        assert property (@(posedge clk) disable iff (reset)
            imem_valid[w] && !imem_ready[w] |=> imem_valid[w] && $stable(imem_addr[w]));
    end

endmodule

`default_nettype wire

/* design/instr_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
    input  wire                   clk,
    input  wire                   reset,
    input  logic                  decoding,
    input  simt_pkg::instr_t      cur_instr,
    output simt_pkg::opcode_e     opcode,
    output logic                  scalar,
    output simt_pkg::reg_addr_t   rd,
    output simt_pkg::reg_addr_t   rs1,
    output simt_pkg::reg_addr_t   rs2,
    output simt_pkg::data_t       imm,
    output logic                  reg_write,
    output logic                  is_branch,
    output logic                  is_halt
);
    import simt_pkg::*;

    logic [3:0] raw_op;
    opcode_e    op_next;

    assign raw_op = cur_instr[OPC_MSB:OPC_LSB];

    // Unused codes fall back to halt
    always_comb begin
        if (raw_op <= OP_HALT)
            op_next = opcode_e'(raw_op);
        else
            op_next = OP_HALT;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            opcode    <= OP_HALT;
            scalar    <= 1'b0;
            reg_write <= 1'b0;
            is_branch <= 1'b0;
            is_halt   <= 1'b0;
        end else if (decoding) begin
            opcode    <= op_next;
            scalar    <= cur_instr[SCALAR_BIT];
            reg_write <= (op_next != OP_BNE) && (op_next != OP_HALT);
            is_branch <= (op_next == OP_BNE);
            is_halt   <= (op_next == OP_HALT);
        end
    end

    // Register indices and immediate
    always_ff @(posedge clk) begin
        if (decoding) begin
            rd  <= cur_instr[RD_LSB +: 3];
            rs1 <= cur_instr[RS1_LSB +: 3];
            rs2 <= cur_instr[RS2_LSB +: 3];
            imm <= {{(32 - IMM_W){cur_instr[IMM_W-1]}}, cur_instr[IMM_W-1:0]};
        end
    end

endmodule

`default_nettype wire

/* design/lane_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module lane_alu (
    input  simt_pkg::opcode_e   opcode,
    input  simt_pkg::data_t     op1,
    input  simt_pkg::data_t     op2,
    input  simt_pkg::data_t     imm,
    input  simt_pkg::data_t     lane_id,
    output simt_pkg::data_t     result,
    output logic                not_equal
);
    import simt_pkg::*;

    logic less;

    // Signed compare for set-less-than
    assign less = ($signed(op1) < $signed(op2));

    always_comb begin
        case (opcode)
            OP_ADD:    result = op1 + op2;
            OP_SUB:    result = op1 - op2;
            OP_AND:    result = op1 & op2;
            OP_OR:     result = op1 | op2;
            OP_XOR:    result = op1 ^ op2;
            OP_SLT:    result = data_t'(less);
            OP_ADDI:   result = op1 + imm;
            OP_LI:     result = imm;
            OP_LANEID: result = lane_id;
            // Branch and halt write nothing
            default:   result = '0;
        endcase
    end

    // Branch condition for OP_BNE
    assign not_equal = (op1 != op2);

endmodule

`default_nettype wire

/* design/warp_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module warp_regs (
    input  wire                   clk,
    input  wire                   reset,
    input  logic                  write,
    input  logic                  scalar,
    input  simt_pkg::reg_addr_t   rd,
    input  simt_pkg::reg_addr_t   rs1,
    input  simt_pkg::reg_addr_t   rs2,
    input  simt_pkg::data_t       scalar_result,
    input  simt_pkg::data_t       lane_results [simt_pkg::NUM_LANES],
    output simt_pkg::data_t       scalar_rs1,
    output simt_pkg::data_t       scalar_rs2,
    output simt_pkg::data_t       lane_rs1 [simt_pkg::NUM_LANES],
    output simt_pkg::data_t       lane_rs2 [simt_pkg::NUM_LANES],
    input  logic                  debug_scalar,
    input  simt_pkg::reg_addr_t   debug_reg,
    input  simt_pkg::lane_idx_t   debug_lane,
    output simt_pkg::data_t       debug_data
);
    import simt_pkg::*;

    data_t      scalar_rf [NUM_REGS];
    data_t      vector_rf [NUM_LANES][NUM_REGS];
    logic       scalar_we;
    lane_mask_t lane_we;

    // Scalar flag steers the write to one file or all lanes
    assign scalar_we = write && scalar;
    assign lane_we   = {NUM_LANES{write && !scalar}};

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                scalar_rf[r] <= '0;
                for (int l = 0; l < NUM_LANES; l++)
                    vector_rf[l][r] <= '0;
            end
        end else begin
            if (scalar_we)
                scalar_rf[rd] <= scalar_result;
            for (int l = 0; l < NUM_LANES; l++) begin
                if (lane_we[l])
                    vector_rf[l][rd] <= lane_results[l];
            end
        end
    end

    // Operand reads
    assign scalar_rs1 = scalar_rf[rs1];
    assign scalar_rs2 = scalar_rf[rs2];

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane_read
        assign lane_rs1[l] = vector_rf[l][rs1];
        assign lane_rs2[l] = vector_rf[l][rs2];
    end

    assign debug_data = debug_scalar ? scalar_rf[debug_reg] : vector_rf[debug_lane][debug_reg];

    assert property (@(posedge clk) reset |-> !write);

endmodule

`default_nettype wire

/* design/compute_core.sv */
`timescale 1ns/10ps
`default_nettype none

module compute_core (
    input  wire                       clk,
    input  wire                       reset,
    input  logic                      start,
    input  simt_pkg::warp_count_t     num_warps,
    input  simt_pkg::pc_t             base_pc,
    output logic                      done,
    output logic [simt_pkg::NUM_WARPS-1:0] imem_valid,
    output simt_pkg::pc_t             imem_addr [simt_pkg::NUM_WARPS],
    input  logic [simt_pkg::NUM_WARPS-1:0] imem_ready,
    input  simt_pkg::instr_t          imem_data [simt_pkg::NUM_WARPS],
    input  simt_pkg::warp_idx_t       debug_warp,
    input  logic                      debug_scalar,
    input  simt_pkg::reg_addr_t       debug_reg,
    input  simt_pkg::lane_idx_t       debug_lane,
    output simt_pkg::data_t           debug_data
);
    import simt_pkg::*;

    warp_idx_t cur_warp;
    instr_t    cur_instr;
    logic      decoding;
    logic      executing;
    opcode_e   opcode;
    logic      scalar;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    data_t     imm;
    logic      reg_write;
    logic      is_branch;
    logic      is_halt;
    logic      branch_ne;
    data_t     warp_base;
    data_t     scalar_result;
    data_t     lane_results [NUM_LANES];
    data_t     scalar_rs1_w [NUM_WARPS];
    data_t     scalar_rs2_w [NUM_WARPS];
    data_t     lane_rs1_w [NUM_WARPS][NUM_LANES];
    data_t     lane_rs2_w [NUM_WARPS][NUM_LANES];
    data_t     debug_w [NUM_WARPS];

    warp_scheduler warp_scheduler_i (
        .clk(clk), .reset(reset), .start(start), .num_warps(num_warps), .base_pc(base_pc),
        .imem_valid(imem_valid), .imem_addr(imem_addr),
        .imem_ready(imem_ready), .imem_data(imem_data),
        .cur_warp(cur_warp), .cur_instr(cur_instr),
        .decoding(decoding), .executing(executing),
        .is_branch(is_branch), .is_halt(is_halt),
        .branch_imm(imm), .branch_ne(branch_ne), .done(done)
    );

    instr_decoder instr_decoder_i (
        .clk(clk), .reset(reset), .decoding(decoding), .cur_instr(cur_instr),
        .opcode(opcode), .scalar(scalar), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm),
        .reg_write(reg_write), .is_branch(is_branch), .is_halt(is_halt)
    );

    // First global lane id of the selected warp
    assign warp_base = data_t'(cur_warp) * data_t'(NUM_LANES);

    // Scalar unit also supplies the branch compare
    lane_alu scalar_alu_i (
        .opcode(opcode), .op1(scalar_rs1_w[cur_warp]), .op2(scalar_rs2_w[cur_warp]),
        .imm(imm), .lane_id(warp_base), .result(scalar_result), .not_equal(branch_ne)
    );

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        lane_alu lane_alu_i (
            .opcode(opcode), .op1(lane_rs1_w[cur_warp][l]), .op2(lane_rs2_w[cur_warp][l]),
            .imm(imm), .lane_id(warp_base + data_t'(l)),
            .result(lane_results[l]), .not_equal()
        );
    end

    for (genvar w = 0; w < NUM_WARPS; w++) begin : g_warp
        warp_regs warp_regs_i (
            .clk(clk), .reset(reset),
            .write(executing && (cur_warp == warp_idx_t'(w)) && reg_write),
            .scalar(scalar), .rd(rd), .rs1(rs1), .rs2(rs2),
            .scalar_result(scalar_result), .lane_results(lane_results),
            .scalar_rs1(scalar_rs1_w[w]), .scalar_rs2(scalar_rs2_w[w]),
            .lane_rs1(lane_rs1_w[w]), .lane_rs2(lane_rs2_w[w]),
            .debug_scalar(debug_scalar), .debug_reg(debug_reg), .debug_lane(debug_lane),
            .debug_data(debug_w[w])
        );
    end

    assign debug_data = debug_w[debug_warp];

endmodule

`default_nettype wire

/* tb/core_ref_model.svh */
`ifndef CORE_REF_MODEL_SVH
`define CORE_REF_MODEL_SVH

// Packs the fields into one instruction word
function automatic instr_t encode(logic [3:0] op, bit s, int rd, int rs1, int rs2, int imm);
    return {op, s, 3'(rd), 3'(rs1), 3'(rs2), 18'(imm)};
endfunction

// Integer result of one lane or of the scalar unit
function automatic data_t model_alu(logic [3:0] op, data_t a, data_t b, data_t imm, data_t lid);
    case (op)
        OP_ADD:    return a + b;
        OP_SUB:    return a - b;
        OP_AND:    return a & b;
        OP_OR:     return a | b;
        OP_XOR:    return a ^ b;
        OP_SLT:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        OP_ADDI:   return a + imm;
        OP_LI:     return imm;
        OP_LANEID: return lid;
        default:   return '0;
    endcase
endfunction

// Kind 0 is vector only, kind 1 scalar with branches, kind 2 mixed
task automatic gen_program(int kind, pc_t base);
    int len;
    logic [3:0] op;
    bit s;
    len = 8 + int'($urandom_range(16, 0));
    for (int i = 0; i < len - 1; i++) begin
        s = (kind == 1) || (kind == 2 && $urandom_range(1, 0) == 1);
        if (i < 2)
            op = (i == 0) ? OP_LANEID : OP_LI;
        else
            op = 4'($urandom_range((kind == 0) ? 8 : 9, 0));
        // Forward target, never past the final halt
        if (op == OP_BNE)
            mem[base + pc_t'(i)] = encode(op, s, 0, $urandom_range(7, 0), $urandom_range(7, 0),
                                          1 + int'($urandom_range(len - 2 - i, 0)));
        else
            mem[base + pc_t'(i)] = encode(op, s, (i < 2) ? i + 1 : $urandom_range(7, 0),
                                          $urandom_range(7, 0), $urandom_range(7, 0), $urandom);
    end
    mem[base + pc_t'(len - 1)] = encode(OP_HALT, 1'b0, 0, 0, 0, 0);
endtask

// Runs one warp to its halt and records each fetch address
task automatic run_model(int w, pc_t base);
    pc_t pc;
    instr_t word;
    logic [3:0] op;
    data_t imm;
    int rd;
    int rs1;
    int rs2;
    pc = base;
    for (int step = 0; step < 64; step++) begin
        ref_trace[w].push_back(pc);
        word = mem[pc];
        op = word[31:28];
        rd = int'(word[26:24]);
        rs1 = int'(word[23:21]);
        rs2 = int'(word[20:18]);
        imm = {{14{word[17]}}, word[17:0]};
        if (op >= OP_HALT)
            break;
        if (op == OP_BNE) begin
            pc = (ref_sreg[w][rs1] != ref_sreg[w][rs2]) ? pc + imm[15:0] : pc + 16'd1;
        end else begin
            if (word[27])
                ref_sreg[w][rd] = model_alu(op, ref_sreg[w][rs1], ref_sreg[w][rs2], imm,
                                            w * NUM_LANES);
            else
                for (int l = 0; l < NUM_LANES; l++)
                    ref_vreg[w][l][rd] = model_alu(op, ref_vreg[w][l][rs1], ref_vreg[w][l][rs2],
                                                   imm, w * NUM_LANES + l);
            pc = pc + 16'd1;
        end
    end
endtask

`endif

/* tb/compute_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module compute_core_tb;
    import simt_pkg::*;

    localparam int TIMEOUT_CYCLES = 5000;

    logic                 clk;
    logic                 reset;
    logic                 start;
    warp_count_t          num_warps;
    pc_t                  base_pc;
    logic                 done;
    logic [NUM_WARPS-1:0] imem_valid;
    pc_t                  imem_addr [NUM_WARPS];
    logic [NUM_WARPS-1:0] imem_ready;
    instr_t               imem_data [NUM_WARPS];
    warp_idx_t            debug_warp;
    logic                 debug_scalar;
    reg_addr_t            debug_reg;
    lane_idx_t            debug_lane;
    data_t                debug_data;

    // Instruction memory and model state
    instr_t mem [65536];
    data_t  ref_sreg [NUM_WARPS][NUM_REGS];
    data_t  ref_vreg [NUM_WARPS][NUM_LANES][NUM_REGS];
    pc_t    ref_trace [NUM_WARPS][$];
    pc_t    dut_trace [NUM_WARPS][$];
    int     lat_cnt [NUM_WARPS];
    int     latency_max;
    int     active_warps;
    int     stray_valid;
    int     checks;
    int     errors;
    bit     aborted;

    `include "core_ref_model.svh"

    compute_core compute_core_i (
        .clk(clk), .reset(reset), .start(start), .num_warps(num_warps), .base_pc(base_pc),
        .done(done), .imem_valid(imem_valid), .imem_addr(imem_addr),
        .imem_ready(imem_ready), .imem_data(imem_data),
        .debug_warp(debug_warp), .debug_scalar(debug_scalar), .debug_reg(debug_reg),
        .debug_lane(debug_lane), .debug_data(debug_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Memory responder raises ready after 0 to latency_max idle cycles
    initial begin
        imem_ready = '0;
        stray_valid = 0;
        for (int w = 0; w < NUM_WARPS; w++)
            imem_data[w] = '0;
        forever begin
            @(posedge clk);
            for (int w = 0; w < NUM_WARPS; w++) begin
                if (reset) begin
                    imem_ready[w] <= 1'b0;
                    dut_trace[w].delete();
                    lat_cnt[w] = int'($urandom_range(latency_max, 0));
                end else if (imem_valid[w]) begin
                    if (w >= active_warps)
                        stray_valid++;
                    if (imem_ready[w]) begin
                        // Handshake on this edge
                        dut_trace[w].push_back(imem_addr[w]);
                        imem_ready[w] <= 1'b0;
                        lat_cnt[w] = int'($urandom_range(latency_max, 0));
                    end else if (lat_cnt[w] == 0) begin
                        imem_ready[w] <= 1'b1;
                        imem_data[w] <= mem[imem_addr[w]];
                    end else begin
                        lat_cnt[w]--;
                    end
                end
            end
            if (reset)
                stray_valid = 0;
        end
    end

    task automatic check_value(string name, data_t got, data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
    endtask

    task automatic read_debug(int w, bit s, int r, int l, output data_t v);
        @(posedge clk);
        debug_warp <= warp_idx_t'(w);
        debug_scalar <= s;
        debug_reg <= reg_addr_t'(r);
        debug_lane <= lane_idx_t'(l);
        @(negedge clk);
        v = debug_data;
    endtask

    task automatic check_regs();
        data_t v;
        for (int w = 0; w < NUM_WARPS; w++) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                read_debug(w, 1'b1, r, 0, v);
                check_value($sformatf("scalar w%0d r%0d", w, r), v, ref_sreg[w][r]);
                for (int l = 0; l < NUM_LANES; l++) begin
                    read_debug(w, 1'b0, r, l, v);
                    check_value($sformatf("vector w%0d l%0d r%0d", w, l, r), v, ref_vreg[w][l][r]);
                end
            end
        end
    endtask

    task automatic clear_model();
        for (int w = 0; w < NUM_WARPS; w++) begin
            ref_trace[w].delete();
            for (int r = 0; r < NUM_REGS; r++) begin
                ref_sreg[w][r] = '0;
                for (int l = 0; l < NUM_LANES; l++)
                    ref_vreg[w][l][r] = '0;
            end
        end
    endtask

    task automatic do_run(int kind, int nw, int lat);
        pc_t base;
        int cycles;
        if (aborted)
            return;
        latency_max = lat;
        active_warps = nw;
        base = pc_t'($urandom);
        // Unused space holds unused opcodes tagged with their address
        for (int a = 0; a < 65536; a++)
            mem[a] = {4'hF, 12'h0, a[15:0]};
        gen_program(kind, base);
        clear_model();
        for (int w = 0; w < nw; w++)
            run_model(w, base);
        apply_reset();
        num_warps <= warp_count_t'(nw);
        base_pc <= base;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!done && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            errors++;
            aborted = 1'b1;
            $display("Timeout: done did not rise within %0d cycles", TIMEOUT_CYCLES);
            return;
        end
        for (int w = 0; w < NUM_WARPS; w++) begin
            check_value($sformatf("trace length w%0d", w), dut_trace[w].size(), ref_trace[w].size());
            if (dut_trace[w].size() == ref_trace[w].size())
                for (int i = 0; i < ref_trace[w].size(); i++)
                    check_value($sformatf("imem_addr w%0d fetch %0d", w, i),
                                dut_trace[w][i], ref_trace[w][i]);
        end
        check_value("inactive imem_valid count", stray_valid, 0);
        check_regs();
    endtask

    task automatic report_test(int num, string name, int errs_before);
        if (aborted && errors == errs_before)
            $display("Test %0d %s: skipped", num, name);
        else
            $display("Test %0d %s: %s", num, name, (errors == errs_before) ? "ok" : "FAILED");
    endtask

    initial begin
        int seed;
        int e;
        seed = $urandom(32'h967f_7154);
        reset = 1'b1;
        start = 1'b0;
        num_warps = 3'd4;
        base_pc = '0;
        debug_warp = '0;
        debug_scalar = 1'b0;
        debug_reg = '0;
        debug_lane = '0;
        latency_max = 0;
        active_warps = 0;
        checks = 0;
        errors = 0;
        aborted = 1'b0;

        e = errors;
        do_run(0, 4, 0);
        report_test(2, "vector arithmetic", e);

        e = errors;
        do_run(1, 4, 0);
        report_test(3, "scalar arithmetic and branches", e);

        e = errors;
        do_run(2, 1, 1);
        do_run(2, 3, 1);
        report_test(4, "partial blocks", e);

        e = errors;
        repeat (3) do_run(2, 4, 3);
        report_test(5, "back-pressure", e);

        // Reset after a finished run, with done high and registers written
        e = errors;
        if (!aborted) begin
            clear_model();
            apply_reset();
            @(negedge clk);
            check_value("done", done, 0);
            check_value("imem_valid", imem_valid, 0);
            check_regs();
        end
        report_test(1, "reset state", e);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+tb
design/simt_pkg.sv
design/warp_scheduler.sv
design/instr_decoder.sv
design/lane_alu.sv
design/warp_regs.sv
design/compute_core.sv
tb/compute_core_tb.sv

/* run.sh */
#!/bin/sh
# Compile with Verilator, run, and decide by the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module compute_core_tb \
    -o compute_core_tb > build.log 2>&1 \
    && ./obj_dir/compute_core_tb > sim.log 2>&1 \
    || { cat build.log; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "^Regression passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
